/* Bender.yml */
package:
  name: dma_subsystem

sources:
  - logic/dma_pkg.sv
  - logic/dma_bus_if.sv
  - logic/dma_engine.sv
  - logic/line_buffer.sv
  - logic/bus_arbiter.sv
  - logic/bus_memory.sv
  - logic/dma_subsystem.sv
  - target: test
    files:
      - tb/dma_subsystem_checker.sv
      - tb/dma_subsystem_tb.sv

/* list.f */
logic/dma_pkg.sv
logic/dma_bus_if.sv
logic/dma_engine.sv
logic/line_buffer.sv
logic/bus_arbiter.sv
logic/bus_memory.sv
logic/dma_subsystem.sv
tb/dma_subsystem_checker.sv
tb/dma_subsystem_tb.sv

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clock,
    input  logic reset,
    input  logic request_engine,
    input  logic request_external,
    output logic grant_engine,
    output logic grant_external
);

    logic held_engine;    // grant of the previous cycle
    logic held_external;
    logic last_engine;    // engine owned the bus last

    always_comb begin
        grant_engine   = 1'b0;
        grant_external = 1'b0;
        if (held_engine && request_engine) begin
            grant_engine = 1'b1;
        end else if (held_external && request_external) begin
            grant_external = 1'b1;
        end else if (request_engine && request_external) begin
            // tie goes to whoever did not own it last
            if (last_engine)
                grant_external = 1'b1;
            else
                grant_engine = 1'b1;
        end else if (request_engine) begin
            grant_engine = 1'b1;
        end else if (request_external) begin
            grant_external = 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            held_engine   <= 1'b0;
            held_external <= 1'b0;
            last_engine   <= 1'b0;
        end else begin
            held_engine   <= grant_engine;
            held_external <= grant_external;
            if (grant_engine)
                last_engine <= 1'b1;
            else if (grant_external)
                last_engine <= 1'b0;
        end
    end

endmodule

/* logic/bus_memory.sv */
`timescale 1ns/1ps

module bus_memory (
    input  logic      clock,
    input  logic      reset,
    dma_bus_if.target bus
);

    dma_pkg::word_t         storage [dma_pkg::MEMORY_WORDS];
    dma_pkg::word_t         offset;
    dma_pkg::memory_index_t index_q;
    dma_pkg::wait_count_t   wait_count;
    dma_pkg::word_t         read_data_q;

    logic address_ok;
    logic active;
    logic is_read;
    logic sent;        // read word already returned
    logic error_q;
    logic valid_q;
    logic data_phase;

    assign offset     = bus.address_data - dma_pkg::BUS_BASE;
    assign address_ok = (offset < dma_pkg::word_t'(dma_pkg::MEMORY_WORDS * 4)) &&
                        (bus.address_data[1:0] == 2'b00);
    assign data_phase = active && (wait_count == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            active     <= 1'b0;
            is_read    <= 1'b0;
            sent       <= 1'b0;
            error_q    <= 1'b0;
            valid_q    <= 1'b0;
            wait_count <= '0;
        end else begin
            error_q <= 1'b0;
            valid_q <= 1'b0;
            if (bus.begin_transaction) begin
                active     <= address_ok;
                error_q    <= !address_ok;  // one-cycle pulse after begin
                is_read    <= bus.read_n_write;
                sent       <= 1'b0;
                wait_count <= address_ok ? dma_pkg::wait_count_t'(dma_pkg::WAIT_CYCLES) : '0;
            end else if (active) begin
                if (bus.end_transaction) begin
                    active <= 1'b0;
                end else if (wait_count != '0) begin
                    wait_count <= wait_count - 1'b1;
                end else if (is_read && !sent) begin
                    valid_q <= 1'b1;
                    sent    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus.begin_transaction)
            index_q <= offset[$bits(dma_pkg::memory_index_t)+1:2];
        if (data_phase && !is_read && bus.data_valid)
            storage[index_q] <= bus.address_data;
        if (data_phase && is_read && !sent)
            read_data_q <= storage[index_q];
    end

    assign bus.target_busy       = active && (wait_count != '0);
    assign bus.target_error      = error_q;
    assign bus.target_data_valid = valid_q;
    assign bus.target_data       = read_data_q;

endmodule

/* logic/dma_bus_if.sv */
`timescale 1ns/1ps

interface dma_bus_if;

    // master side
    dma_pkg::word_t address_data;  // address in the begin cycle, write data after
    logic           read_n_write;
    logic           begin_transaction;
    logic           end_transaction;
    logic           data_valid;

    // target side
    dma_pkg::word_t target_data;
    logic           target_data_valid;
    logic           target_busy;
    logic           target_error;

    modport master (
        output address_data,
        output read_n_write,
        output begin_transaction,
        output end_transaction,
        output data_valid,
        input  target_data,
        input  target_data_valid,
        input  target_busy,
        input  target_error
    );

    modport target (
        input  address_data,
        input  read_n_write,
        input  begin_transaction,
        input  end_transaction,
        input  data_valid,
        output target_data,
        output target_data_valid,
        output target_busy,
        output target_error
    );

endinterface

/* logic/dma_engine.sv */
`timescale 1ns/1ps

module dma_engine (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_start,
    input  logic                   read_start,
    input  dma_pkg::word_t         bus_address,
    input  dma_pkg::buffer_index_t buffer_index,
    output logic                   busy,
    output logic                   done,
    output logic                   error,
    output logic                   request,
    input  logic                   granted,
    output dma_pkg::buffer_index_t buffer_read_index,
    output dma_pkg::buffer_index_t buffer_write_index,
    output logic                   buffer_write,
    output dma_pkg::word_t         buffer_write_data,
    input  dma_pkg::word_t         buffer_read_data,
    dma_bus_if.master              bus
);

    dma_pkg::engine_state_t state;
    dma_pkg::engine_state_t next_state;

    dma_pkg::word_t         address_q;
    dma_pkg::buffer_index_t index_q;
    dma_pkg::word_t         data_q;     // word in flight
    logic                   error_q;

    logic accept;
    logic bus_phase;  // states in which the target may answer

    assign accept = (state == dma_pkg::idle) && (write_start || read_start);

    assign bus_phase = (state == dma_pkg::write_address) || (state == dma_pkg::write_data) ||
                       (state == dma_pkg::read_address) || (state == dma_pkg::read_data);

    always_comb begin
        next_state = state;
        if (bus_phase && bus.target_error) begin
            next_state = dma_pkg::abort;
        end else begin
            case (state)
                dma_pkg::idle: begin
                    if (write_start)
                        next_state = dma_pkg::fetch_buffer;  // write wins a tie
                    else if (read_start)
                        next_state = dma_pkg::read_request;
                end
                dma_pkg::fetch_buffer:  next_state = dma_pkg::write_request;
                dma_pkg::write_request: begin
                    if (granted)
                        next_state = dma_pkg::write_address;
                end
                dma_pkg::write_address: next_state = dma_pkg::write_data;
                dma_pkg::write_data: begin
                    if (!bus.target_busy)
                        next_state = dma_pkg::finish;
                end
                dma_pkg::read_request: begin
                    if (granted)
                        next_state = dma_pkg::read_address;
                end
                dma_pkg::read_address:  next_state = dma_pkg::read_data;
                dma_pkg::read_data: begin
                    if (bus.target_data_valid)
                        next_state = dma_pkg::store_buffer;
                end
                dma_pkg::store_buffer:  next_state = dma_pkg::finish;
                dma_pkg::abort:         next_state = dma_pkg::finish;
                dma_pkg::finish:        next_state = dma_pkg::idle;
                default:                next_state = dma_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state   <= dma_pkg::idle;
            error_q <= 1'b0;
        end else begin
            state <= next_state;
            if (accept)
                error_q <= 1'b0;
            else if (state == dma_pkg::abort)
                error_q <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            address_q <= bus_address;
            index_q   <= buffer_index;
        end
        // buffer word shows up one cycle after fetch_buffer
        if (state == dma_pkg::write_request)
            data_q <= buffer_read_data;
        else if (state == dma_pkg::read_data && bus.target_data_valid)
            data_q <= bus.target_data;
    end

    assign busy  = (state != dma_pkg::idle);
    assign done  = (state == dma_pkg::finish);
    assign error = done && error_q;

    // keep the bus until the transaction is closed
    assign request = (state == dma_pkg::write_request) || (state == dma_pkg::read_request) ||
                     bus_phase || (state == dma_pkg::store_buffer) ||
                     (state == dma_pkg::abort);

    assign buffer_read_index  = index_q;
    assign buffer_write_index = index_q;
    assign buffer_write       = (state == dma_pkg::store_buffer);
    assign buffer_write_data  = data_q;

    assign bus.begin_transaction = (state == dma_pkg::write_address) ||
                                   (state == dma_pkg::read_address);
    assign bus.read_n_write      = (state == dma_pkg::read_address);
    assign bus.data_valid        = (state == dma_pkg::write_data);
    assign bus.address_data      = bus.begin_transaction ? address_q :
                                   bus.data_valid ? data_q : '0;

    always_comb begin
        bus.end_transaction = 1'b0;
        if (state == dma_pkg::write_data)
            bus.end_transaction = !bus.target_busy && !bus.target_error;
        else if (state == dma_pkg::store_buffer || state == dma_pkg::abort)
            bus.end_transaction = 1'b1;
    end

endmodule

/* logic/dma_pkg.sv */
package dma_pkg;

    typedef logic [31:0] word_t;          // bus address or data word
    typedef logic [8:0]  buffer_index_t;  // line buffer entry
    typedef logic [7:0]  memory_index_t;  // word inside the memory window

    localparam int    BUFFER_WORDS = 512;
    localparam word_t BUS_BASE     = 32'h4000_0000;
    localparam int    MEMORY_WORDS = 256;

    // busy cycles the target inserts before each data phase
    localparam int WAIT_CYCLES      = 2;
    localparam int WAIT_COUNT_WIDTH = $clog2(WAIT_CYCLES + 1);

    typedef logic [WAIT_COUNT_WIDTH-1:0] wait_count_t;

    typedef enum logic [3:0] {
        idle,
        fetch_buffer,
        write_request,
        write_address,
        write_data,
        read_request,
        read_address,
        read_data,
        store_buffer,
        finish,
        abort
    } engine_state_t;

endpackage

/* logic/dma_subsystem.sv */
`timescale 1ns/1ps

module dma_subsystem (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_start,
    input  logic                   read_start,
    input  dma_pkg::word_t         bus_address,
    input  dma_pkg::buffer_index_t buffer_index,
    output logic                   busy,
    output logic                   done,
    output logic                   error,
    input  dma_pkg::buffer_index_t host_index,
    input  logic                   host_write,
    input  dma_pkg::word_t         host_write_data,
    output dma_pkg::word_t         host_read_data,
    input  logic                   external_request,
    output logic                   external_grant,
    input  logic                   external_begin,
    input  logic                   external_read_n_write,
    input  dma_pkg::word_t         external_address_data,
    input  logic                   external_data_valid,
    input  logic                   external_end,
    output logic                   external_target_busy,
    output logic                   external_target_data_valid,
    output dma_pkg::word_t         external_target_data,
    output logic                   external_target_error
);

    logic                   request_engine;
    logic                   grant_engine;
    dma_pkg::buffer_index_t buffer_read_index;
    dma_pkg::buffer_index_t buffer_write_index;
    logic                   buffer_write;
    dma_pkg::word_t         buffer_write_data;
    dma_pkg::word_t         buffer_read_data;

    dma_bus_if engine_bus ();  // engine side, before the grant mux
    dma_bus_if shared_bus ();  // what the memory sees

    dma_engine u_dma_engine (
        .clock(clock), .reset(reset),
        .write_start(write_start), .read_start(read_start),
        .bus_address(bus_address), .buffer_index(buffer_index),
        .busy(busy), .done(done), .error(error),
        .request(request_engine), .granted(grant_engine),
        .buffer_read_index(buffer_read_index), .buffer_write_index(buffer_write_index),
        .buffer_write(buffer_write), .buffer_write_data(buffer_write_data),
        .buffer_read_data(buffer_read_data), .bus(engine_bus.master)
    );

    line_buffer u_line_buffer (
        .clock(clock),
        .engine_read_index(buffer_read_index), .engine_read_data(buffer_read_data),
        .engine_write(buffer_write), .engine_write_index(buffer_write_index),
        .engine_write_data(buffer_write_data),
        .host_index(host_index), .host_write(host_write),
        .host_write_data(host_write_data), .host_read_data(host_read_data)
    );

    bus_arbiter u_bus_arbiter (
        .clock(clock), .reset(reset),
        .request_engine(request_engine), .request_external(external_request),
        .grant_engine(grant_engine), .grant_external(external_grant)
    );

    bus_memory u_bus_memory (.clock(clock), .reset(reset), .bus(shared_bus.target));

    // master strobes only pass for the granted side
    assign shared_bus.address_data      = external_grant ? external_address_data :
                                                           engine_bus.address_data;
    assign shared_bus.read_n_write      = external_grant ? external_read_n_write :
                                                           engine_bus.read_n_write;
    assign shared_bus.begin_transaction = (grant_engine && engine_bus.begin_transaction) ||
                                          (external_grant && external_begin);
    assign shared_bus.end_transaction   = (grant_engine && engine_bus.end_transaction) ||
                                          (external_grant && external_end);
    assign shared_bus.data_valid        = (grant_engine && engine_bus.data_valid) ||
                                          (external_grant && external_data_valid);

    assign engine_bus.target_data       = shared_bus.target_data;
    assign engine_bus.target_data_valid = grant_engine && shared_bus.target_data_valid;
    assign engine_bus.target_busy       = grant_engine && shared_bus.target_busy;
    assign engine_bus.target_error      = grant_engine && shared_bus.target_error;

    assign external_target_data         = shared_bus.target_data;
    assign external_target_data_valid   = external_grant && shared_bus.target_data_valid;
    assign external_target_busy         = external_grant && shared_bus.target_busy;
    assign external_target_error        = external_grant && shared_bus.target_error;

endmodule

/* logic/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
    input  logic                   clock,
    input  dma_pkg::buffer_index_t engine_read_index,
    output dma_pkg::word_t         engine_read_data,
    input  logic                   engine_write,
    input  dma_pkg::buffer_index_t engine_write_index,
    input  dma_pkg::word_t         engine_write_data,
    input  dma_pkg::buffer_index_t host_index,
    input  logic                   host_write,
    input  dma_pkg::word_t         host_write_data,
    output dma_pkg::word_t         host_read_data
);

    dma_pkg::word_t storage [dma_pkg::BUFFER_WORDS];

    always_ff @(posedge clock) begin
        if (engine_write)
            storage[engine_write_index] <= engine_write_data;
        // host comes last so it wins on the same entry
        if (host_write)
            storage[host_index] <= host_write_data;
    end

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clock) begin
        engine_read_data <= storage[engine_read_index];
        host_read_data   <= storage[host_index];
    end

endmodule

/* tb/dma_subsystem_checker.sv */
`timescale 1ns/1ps

module dma_subsystem_checker (
    input logic clock,
    input logic reset,
    input logic request,
    input logic granted,
    input logic done,
    input logic begin_transaction
);

    bit violation = 1'b0;  // sticky flag read by the testbench

    begin_needs_grant: assert property (@(posedge clock) disable iff (reset)
        begin_transaction |-> granted)
        else begin
            $error("begin_transaction raised without a bus grant");
            violation = 1'b1;
        end

    begin_single_cycle: assert property (@(posedge clock) disable iff (reset)
        begin_transaction |=> !begin_transaction)
        else begin
            $error("begin_transaction held longer than one cycle");
            violation = 1'b1;
        end

    done_single_cycle: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else begin
            $error("done held longer than one cycle");
            violation = 1'b1;
        end

    // a pending request may not be withdrawn before the grant
    request_until_grant: assert property (@(posedge clock) disable iff (reset)
        request && !granted |=> request)
        else begin
            $error("request dropped before the grant arrived");
            violation = 1'b1;
        end

endmodule

bind dma_engine dma_subsystem_checker u_checker (
    .clock(clock), .reset(reset), .request(request), .granted(granted),
    .done(done), .begin_transaction(bus.begin_transaction)
);

/* tb/dma_subsystem_tb.sv */
`timescale 1ns/1ps

module dma_subsystem_tb;

    typedef enum {op_host, op_write, op_read, op_write_twice} op_t;

    logic                   clock;
    logic                   reset;
    logic                   write_start;
    logic                   read_start;
    dma_pkg::word_t         bus_address;
    dma_pkg::buffer_index_t buffer_index;
    logic                   busy;
    logic                   done;
    logic                   error;
    dma_pkg::buffer_index_t host_index;
    logic                   host_write;
    dma_pkg::word_t         host_write_data;
    dma_pkg::word_t         host_read_data;
    logic                   external_request;
    logic                   external_grant;
    logic                   external_begin;
    logic                   external_read_n_write;
    dma_pkg::word_t         external_address_data;
    logic                   external_data_valid;
    logic                   external_end;
    logic                   external_target_busy;
    logic                   external_target_data_valid;
    dma_pkg::word_t         external_target_data;
    logic                   external_target_error;

    // stimulus table with one entry per row in each queue
    string                  row_name [$];
    op_t                    row_op [$];
    dma_pkg::word_t         row_address [$];
    dma_pkg::buffer_index_t row_index [$];
    dma_pkg::word_t         row_data [$];
    bit                     row_external [$];
    bit                     row_error [$];

    dma_pkg::word_t ref_memory [dma_pkg::MEMORY_WORDS];
    dma_pkg::word_t ref_buffer [dma_pkg::BUFFER_WORDS];
    dma_pkg::word_t lcg_state = 32'd70;
    int             cycle_count = 0;
    int             cycle_limit = 0;

    dma_subsystem u_dma_subsystem (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic dma_pkg::word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_row(input string name, input op_t op, input dma_pkg::word_t address,
                           input int index, input bit external, input bit expect_error);
        row_name.push_back(name);
        row_op.push_back(op);
        row_address.push_back(address);
        row_index.push_back(dma_pkg::buffer_index_t'(index));
        row_data.push_back(next_random());
        row_external.push_back(external);
        row_error.push_back(expect_error);
    endtask

    task automatic build_table();
        dma_pkg::word_t random;
        dma_pkg::word_t address;
        add_row("host_round_trip", op_host, '0, 300, 0, 0);
        add_row("write_a", op_write, dma_pkg::BUS_BASE + 32'h10, 5, 0, 0);
        add_row("write_b", op_write, dma_pkg::BUS_BASE + 32'h14, 6, 0, 0);
        add_row("read_a", op_read, dma_pkg::BUS_BASE + 32'h10, 7, 0, 0);
        add_row("write_misaligned", op_write, dma_pkg::BUS_BASE + 32'h12, 8, 0, 1);
        add_row("read_a_after_misaligned", op_read, dma_pkg::BUS_BASE + 32'h10, 9, 0, 0);
        add_row("write_out_of_window", op_write, dma_pkg::BUS_BASE + 32'h400, 10, 0, 1);
        add_row("read_below_window", op_read, 32'h3fff_fffc, 11, 0, 1);
        add_row("read_misaligned", op_read, dma_pkg::BUS_BASE + 32'h11, 12, 0, 1);
        add_row("write_external_held", op_write, dma_pkg::BUS_BASE + 32'h20, 13, 1, 0);
        add_row("read_external_held", op_read, dma_pkg::BUS_BASE + 32'h20, 14, 1, 0);
        add_row("write_strobe_while_busy", op_write_twice, dma_pkg::BUS_BASE + 32'h10, 15, 0, 0);
        add_row("read_b_untouched", op_read, dma_pkg::BUS_BASE + 32'h14, 16, 0, 0);
        add_row("read_a_new", op_read, dma_pkg::BUS_BASE + 32'h10, 17, 0, 0);
        add_row("host_round_trip_top", op_host, '0, 511, 0, 0);
        for (int k = 0; k < 6; k++) begin
            random  = next_random();
            address = dma_pkg::BUS_BASE + {22'd0, random[31:24], 2'b00};
            add_row($sformatf("random_write_%0d", k), op_write, address, random[23:15], 0, 0);
            add_row($sformatf("random_read_%0d", k), op_read, address, random[14:6], 0, 0);
        end
    endtask

    task automatic check_word(input string name, input dma_pkg::word_t expected,
                              input dma_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_true(input bit condition, input string what);
        assert (condition) else begin
            $display("%s", what);
            $display("TB FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic host_store(input dma_pkg::buffer_index_t index, input dma_pkg::word_t data);
        @(negedge clock);
        host_index      = index;
        host_write      = 1'b1;
        host_write_data = data;
        @(negedge clock);
        host_write        = 1'b0;
        ref_buffer[index] = data;
    endtask

    task automatic host_load(input dma_pkg::buffer_index_t index, output dma_pkg::word_t data);
        @(negedge clock);
        host_index = index;
        @(negedge clock);  // registered read
        data = host_read_data;
    endtask

    task automatic strobe_command(input op_t op, input dma_pkg::word_t address,
                                  input dma_pkg::buffer_index_t index);
        @(negedge clock);
        bus_address  = address;
        buffer_index = index;
        write_start  = (op != op_read);
        read_start   = (op == op_read);
        @(negedge clock);
        write_start = 1'b0;
        read_start  = 1'b0;
    endtask

    // one read by the external master while it owns the bus
    task automatic external_read(input dma_pkg::word_t address, input string name);
        dma_pkg::word_t expected;
        expected = ref_memory[dma_pkg::memory_index_t'((address - dma_pkg::BUS_BASE) >> 2)];
        @(negedge clock);
        check_true(external_grant, "external master has no grant while requesting");
        external_address_data = address;
        external_read_n_write = 1'b1;
        external_begin        = 1'b1;
        @(negedge clock);
        external_begin = 1'b0;
        check_true(external_target_busy && !external_target_error,
                   "target not busy after the external begin");
        while (!external_target_data_valid)
            @(negedge clock);
        check_word(name, expected, external_target_data);
        external_end = 1'b1;
        @(negedge clock);
        external_end = 1'b0;
    endtask

    initial begin
        while (!u_dma_subsystem.u_dma_engine.u_checker.violation &&
               (cycle_limit == 0 || cycle_count <= cycle_limit)) begin
            @(posedge clock);
            cycle_count++;
        end
        if (u_dma_subsystem.u_dma_engine.u_checker.violation)
            $display("bus protocol assertion failed at cycle %0d", cycle_count);
        else
            $display("timeout after %0d cycles, done never arrived", cycle_count);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    end

    initial begin
        dma_pkg::word_t         got;
        dma_pkg::memory_index_t slot;
        bit                     error_seen;
        write_start = 1'b0;
        read_start = 1'b0;
        bus_address = '0;
        buffer_index = '0;
        host_index = '0;
        host_write = 1'b0;
        host_write_data = '0;
        external_request = 1'b0;
        external_begin = 1'b0;
        external_read_n_write = 1'b0;
        external_address_data = '0;
        external_data_valid = 1'b0;
        external_end = 1'b0;
        reset = 1'b1;
        build_table();
        cycle_limit = 40 * row_name.size() + 20;  // rows plus reset margin
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_true(!busy && !done && !error && !external_grant,
                   "busy, done, error or external grant high after reset");

        for (int i = 0; i < row_name.size(); i++) begin
            host_store(row_index[i], row_data[i]);
            if (row_op[i] != op_host) begin
                slot = dma_pkg::memory_index_t'((row_address[i] - dma_pkg::BUS_BASE) >> 2);
                if (row_external[i]) begin
                    @(negedge clock);
                    external_request = 1'b1;
                end
                strobe_command(row_op[i], row_address[i], row_index[i]);
                if (row_op[i] == op_write_twice) begin
                    // engine is busy so the second command must be dropped
                    check_true(busy, "engine not busy after an accepted strobe");
                    bus_address  = row_address[i] + 32'h4;
                    buffer_index = row_index[i] + 1'b1;
                    write_start  = 1'b1;
                    @(negedge clock);
                    write_start = 1'b0;
                end
                if (row_external[i]) begin
                    // word left there by write_b
                    external_read(dma_pkg::BUS_BASE + 32'h14, {row_name[i], " external read"});
                    repeat (12) begin
                        @(negedge clock);
                        check_true(busy && !done, "transfer finished while the bus was held");
                    end
                    external_request = 1'b0;
                end
                while (!done)
                    @(negedge clock);
                error_seen = error;
                check_word({row_name[i], " error"}, dma_pkg::word_t'(row_error[i]),
                           dma_pkg::word_t'(error_seen));
                if (row_op[i] == op_write_twice) begin
                    repeat (12) begin
                        @(negedge clock);
                        check_true(!done, "second done after an ignored strobe");
                    end
                end
                if (!row_error[i] && row_op[i] == op_read)
                    ref_buffer[row_index[i]] = ref_memory[slot];
                else if (!row_error[i])
                    ref_memory[slot] = row_data[i];
            end
            host_load(row_index[i], got);
            check_word(row_name[i], ref_buffer[row_index[i]], got);
        end

        repeat (2) @(negedge clock);
        if (u_dma_subsystem.u_dma_engine.u_checker.violation) begin
            $display("bus protocol assertion failed during the run");
            $display("TB FAILED");
            $fatal(1, "protocol violation");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
